// File: hps_io_pkg.sv
package hps_io_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    typedef logic [15:0] io_word_t;
    typedef logic [7:0]  io_byte_t;
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [15:0] byte_cnt_t;

    // host side of the word bus, 18 bits
    typedef struct packed {
        logic     enable;
        logic     strobe;
        io_word_t din;
    } host_bus_t;

    // framer view shared by all function blocks, 51 bits
    typedef struct packed {
        logic      start;
        logic      valid;
        logic      done;
        io_word_t  cmd;
        byte_cnt_t idx;
        io_word_t  data;
    } cmd_frame_t;

    // key event, toggle flips on every accepted event
    typedef struct packed {
        logic     toggle;
        logic     pressed;
        logic     extended;
        io_byte_t code;
    } ps2_key_t;

    ////////////////////
    // command codes
    ////////////////////

    localparam io_word_t cmd_cfg          = 16'h0001;
    localparam io_word_t cmd_joy0         = 16'h0002;
    localparam io_word_t cmd_joy1         = 16'h0003;
    localparam io_word_t cmd_kbd          = 16'h0005;
    localparam io_word_t cmd_status       = 16'h001E;
    localparam io_word_t cmd_led          = 16'h001F;
    localparam io_word_t cmd_file_tx      = 16'h0053;
    localparam io_word_t cmd_file_dat     = 16'h0054;
    localparam io_word_t cmd_file_index   = 16'h0055;
    localparam io_word_t cmd_file_addr_tx = 16'h0058;

    // scan code prefixes
    localparam io_byte_t sc_break = 8'hF0;
    localparam io_byte_t sc_ext   = 8'hE0;

    // raw four byte sequences needing a rewrite
    localparam logic [31:0] sc_prnscr_press   = 32'hE012E07C;
    localparam logic [31:0] sc_prnscr_release = 32'h7CE0F012;
    localparam logic [31:0] sc_pause_press    = 32'hF014F077;

    // replacement {pressed, extended, code}
    localparam logic [9:0] key_prnscr_press   = 10'h37C;
    localparam logic [9:0] key_prnscr_release = 10'h17C;
    localparam logic [9:0] key_pause_press    = 10'h377;

    ////////////////////
    // ps/2 transmitter
    ////////////////////

    // clk_100 cycles per ps/2 half period
    localparam int ps2_div        = 2000;
    localparam int ps2_div_bits   = $clog2(ps2_div);
    localparam int ps2_fifo_bits  = 5;
    localparam int ps2_fifo_depth = 1 << ps2_fifo_bits;

    typedef logic [ps2_div_bits-1:0]  ps2_div_cnt_t;
    typedef logic [ps2_fifo_bits-1:0] ps2_fifo_ptr_t;

    localparam ps2_div_cnt_t ps2_div_last = ps2_div_cnt_t'(ps2_div - 1);

endpackage

// File: host_cmd_frame.sv
module host_cmd_frame (
    input  logic                   clk_100,
    input  logic                   reset,
    input  hps_io_pkg::host_bus_t  host_bus,
    output hps_io_pkg::cmd_frame_t frame
);
    import hps_io_pkg::*;

    // words seen in this frame, saturates at all ones
    byte_cnt_t cnt;
    io_word_t  cmd;
    logic      done;

    always_ff @(posedge clk_100) begin
        if (reset) begin
            cnt  <= '0;
            cmd  <= '0;
            done <= 1'b0;
        end else if (host_bus.enable) begin
            done <= 1'b0;
            if (host_bus.strobe) begin
                // first word of the frame is the command
                if (cnt == '0)
                    cmd <= host_bus.din;
                if (~&cnt)
                    cnt <= cnt + 1'b1;
            end
        end else begin
            // one pulse only when a command was taken
            done <= (cnt != '0);
            cnt  <= '0;
            // cmd survives the done cycle, then clears
            if (cnt == '0)
                cmd <= '0;
        end
    end

    // strobe qualifiers straight off the bus
    always_comb begin
        frame.start = host_bus.enable & host_bus.strobe & (cnt == '0);
        frame.valid = host_bus.enable & host_bus.strobe & (cnt != '0);
        frame.done  = done;
        frame.cmd   = cmd;
        frame.idx   = cnt;
        frame.data  = host_bus.din;
    end

endmodule

// File: user_regs.sv
module user_regs (
    input  logic                   clk_100,
    input  logic                   reset,
    input  hps_io_pkg::cmd_frame_t frame,
    output logic [1:0]             buttons,
    output logic                   forced_scandoubler,
    output hps_io_pkg::io_word_t   joystick_0,
    output hps_io_pkg::io_word_t   joystick_1,
    output logic [31:0]            status
);
    import hps_io_pkg::*;

    // config byte from the host menu
    io_byte_t cfg;

    always_ff @(posedge clk_100) begin
        if (reset) begin
            cfg        <= '0;
            joystick_0 <= '0;
            joystick_1 <= '0;
            status     <= '0;
        end else if (frame.valid) begin
            case (frame.cmd)
                cmd_cfg:
                    cfg <= frame.data[7:0];
                cmd_joy0:
                    joystick_0 <= frame.data;
                cmd_joy1:
                    joystick_1 <= frame.data;
                cmd_status: begin
                    // low half first, extra words ignored
                    if (frame.idx == byte_cnt_t'(1))
                        status[15:0] <= frame.data;
                    else if (frame.idx == byte_cnt_t'(2))
                        status[31:16] <= frame.data;
                end
                default: ;
            endcase
        end
    end

    // cfg bits 2,3,5 belong to the system top
    assign buttons            = cfg[1:0];
    assign forced_scandoubler = cfg[4];

endmodule

// File: file_loader.sv
module file_loader (
    input  logic                    clk_100,
    input  logic                    reset,
    input  hps_io_pkg::cmd_frame_t  frame,
    output logic                    ioctl_download,
    output logic                    ioctl_wr,
    output hps_io_pkg::io_byte_t    ioctl_index,
    output hps_io_pkg::ioctl_addr_t ioctl_addr,
    output hps_io_pkg::io_byte_t    ioctl_dout
);
    import hps_io_pkg::*;

    // running target address
    ioctl_addr_t addr;
    // write request, delayed a cycle into ioctl_wr
    logic        wr;
    logic        data_wr;
    logic        addr_wr;

    // words 1..4 of addr_tx carry the start address
    assign addr_wr = frame.valid && (frame.cmd == cmd_file_addr_tx)
                     && (frame.idx <= byte_cnt_t'(4));

    // every later payload word is a data byte
    assign data_wr = frame.valid && ((frame.cmd == cmd_file_dat)
                     || ((frame.cmd == cmd_file_addr_tx) && !addr_wr));

    always_ff @(posedge clk_100) begin
        if (reset) begin
            addr           <= '0;
            wr             <= 1'b0;
            ioctl_wr       <= 1'b0;
            ioctl_download <= 1'b0;
            ioctl_index    <= '0;
            ioctl_addr     <= '0;
            ioctl_dout     <= '0;
        end else begin
            // address and data settle one cycle before the pulse
            ioctl_wr <= wr;
            wr       <= 1'b0;

            if (frame.done)
                addr <= '0;

            if (frame.valid && frame.cmd == cmd_file_index)
                ioctl_index <= frame.data[7:0];

            // nonzero opens a plain download at 0
            if (frame.valid && frame.cmd == cmd_file_tx) begin
                if (|frame.data[7:0]) begin
                    addr           <= '0;
                    ioctl_download <= 1'b1;
                end else begin
                    ioctl_download <= 1'b0;
                end
            end

            // msb first
            if (addr_wr) begin
                addr <= {addr[16:0], frame.data[7:0]};
                if (frame.idx == byte_cnt_t'(4))
                    ioctl_download <= 1'b1;
            end

            if (data_wr) begin
                ioctl_addr <= addr;
                ioctl_dout <= frame.data[7:0];
                wr         <= 1'b1;
                addr       <= addr + 1'b1;
            end
        end
    end

endmodule

// File: kbd_host.sv
module kbd_host (
    input  logic                   clk_100,
    input  logic                   reset,
    input  hps_io_pkg::cmd_frame_t frame,
    input  logic [2:0]             led_status,
    input  logic [2:0]             led_use,
    output hps_io_pkg::io_word_t   io_dout,
    output hps_io_pkg::ps2_key_t   ps2_key,
    output hps_io_pkg::io_byte_t   kbd_byte,
    output logic                   kbd_push
);
    import hps_io_pkg::*;

    // last four scan bytes, newest in the low byte
    logic [31:0] raw;
    // host marked the frame as not a key event
    logic        skip;
    logic        kbd_word;
    logic        pressed;
    logic        extended;
    logic [9:0]  key_low;
    io_word_t    led_word;

    assign kbd_word = frame.valid && (frame.cmd == cmd_kbd);

    // break hides the extend prefix one byte further back
    assign pressed  = (raw[15:8] != sc_break);
    assign extended = pressed ? (raw[15:8] == sc_ext) : (raw[23:16] == sc_ext);

    // print screen and pause do not fit the usual pattern
    always_comb begin
        case (raw)
            sc_prnscr_press:   key_low = key_prnscr_press;
            sc_prnscr_release: key_low = key_prnscr_release;
            sc_pause_press:    key_low = key_pause_press;
            default:           key_low = {pressed, extended, raw[7:0]};
        endcase
    end

    // status and use per led, led 2 on top
    assign led_word = {8'h00, 2'b01, led_status[2], led_use[2], led_status[1],
                       led_use[1], led_status[0], led_use[0]};

    always_ff @(posedge clk_100) begin
        if (reset) begin
            raw      <= '0;
            skip     <= 1'b0;
            ps2_key  <= '0;
            kbd_byte <= '0;
            kbd_push <= 1'b0;
            io_dout  <= '0;
        end else begin
            kbd_push <= 1'b0;
            if (frame.start) begin
                skip <= 1'b0;
                if (frame.data == cmd_kbd)
                    raw <= '0;
            end
            // every byte goes out on the wire, skipped or not
            if (kbd_word) begin
                kbd_byte <= frame.data[7:0];
                kbd_push <= 1'b1;
                if (&frame.data[15:8])
                    skip <= 1'b1;
                else if (!skip)
                    raw <= {raw[23:0], frame.data[7:0]};
            end
            if (frame.done && frame.cmd == cmd_kbd && !skip)
                ps2_key <= {~ps2_key.toggle, key_low};
            // readback lives from one strobe to the next
            if (frame.done)
                io_dout <= '0;
            else if (frame.valid && frame.cmd == cmd_led)
                io_dout <= led_word;
            else if (frame.start || frame.valid)
                io_dout <= '0;
        end
    end

endmodule

// File: ps2_kbd_tx.sv
module ps2_kbd_tx (
    input  logic                 clk_100,
    input  logic                 reset,
    input  hps_io_pkg::io_byte_t kbd_byte,
    input  logic                 kbd_push,
    output logic                 ps2_clk_out,
    output logic                 ps2_data_out
);
    import hps_io_pkg::*;

    ////////////////////
    // clock divider
    ////////////////////

    ps2_div_cnt_t div_cnt;
    logic         clk_ps2;
    logic         ps2_rise;
    logic         ps2_fall;

    // edges known one cycle early, act on the toggling clock edge
    assign ps2_rise = (div_cnt == ps2_div_last) && !clk_ps2;
    assign ps2_fall = (div_cnt == ps2_div_last) && clk_ps2;

    always_ff @(posedge clk_100) begin
        if (reset) begin
            div_cnt <= '0;
            clk_ps2 <= 1'b0;
        end else if (div_cnt == ps2_div_last) begin
            div_cnt <= '0;
            clk_ps2 <= ~clk_ps2;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////
    // fifo
    ////////////////////

    io_byte_t      fifo_mem [ps2_fifo_depth];
    ps2_fifo_ptr_t wptr;
    ps2_fifo_ptr_t rptr;

    // no full check, a wrapped write pointer drops old bytes
    always_ff @(posedge clk_100) begin
        if (kbd_push)
            fifo_mem[wptr] <= kbd_byte;
    end

    ////////////////////
    // serializer
    ////////////////////

    // 0 idle, 1..11 one state per bit on the wire
    logic [3:0] tx_state;
    io_byte_t   tx_byte;
    logic       parity;

    always_ff @(posedge clk_100) begin
        if (reset) begin
            wptr         <= '0;
            rptr         <= '0;
            tx_state     <= '0;
            tx_byte      <= '0;
            parity       <= 1'b1;
            ps2_data_out <= 1'b1;
            ps2_clk_out  <= 1'b1;
        end else begin
            if (kbd_push)
                wptr <= wptr + 1'b1;

            if (ps2_rise) begin
                ps2_clk_out <= 1'b1;
                if (tx_state == 4'd0) begin
                    if (wptr != rptr) begin
                        // start bit, load the next byte
                        tx_byte      <= fifo_mem[rptr];
                        rptr         <= rptr + 1'b1;
                        parity       <= 1'b1;
                        ps2_data_out <= 1'b0;
                        tx_state     <= 4'd1;
                    end
                end else begin
                    // data lsb first, parity seeded for odd
                    if (tx_state <= 4'd8) begin
                        ps2_data_out <= tx_byte[0];
                        tx_byte      <= {1'b0, tx_byte[7:1]};
                        parity       <= parity ^ tx_byte[0];
                    end else if (tx_state == 4'd9) begin
                        ps2_data_out <= parity;
                    end else if (tx_state == 4'd10) begin
                        // stop bit
                        ps2_data_out <= 1'b1;
                    end
                    tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 1'b1;
                end
            end

            // clock only pulses low while a frame is on the wire
            if (ps2_fall)
                ps2_clk_out <= (tx_state == 4'd0);
        end
    end

endmodule

// File: hps_io.sv
module hps_io (
    input  logic                     clk_100,
    input  logic                     reset,
    input  hps_io_pkg::host_bus_t    host_bus,
    output hps_io_pkg::io_word_t     io_dout,
    output logic [1:0]               buttons,
    output logic                     forced_scandoubler,
    output hps_io_pkg::io_word_t     joystick_0,
    output hps_io_pkg::io_word_t     joystick_1,
    output logic [31:0]              status,
    output logic                     ioctl_download,
    output logic                     ioctl_wr,
    output hps_io_pkg::io_byte_t     ioctl_index,
    output hps_io_pkg::ioctl_addr_t  ioctl_addr,
    output hps_io_pkg::io_byte_t     ioctl_dout,
    input  logic [2:0]               ps2_kbd_led_status,
    input  logic [2:0]               ps2_kbd_led_use,
    output hps_io_pkg::ps2_key_t     ps2_key,
    output logic                     ps2_kbd_clk_out,
    output logic                     ps2_kbd_data_out
);
    import hps_io_pkg::*;

    // decoded frame shared by every block
    cmd_frame_t frame;

    // keyboard bytes toward the serializer
    io_byte_t kbd_byte;
    logic     kbd_push;

    ////////////////////
    // framing
    ////////////////////

    host_cmd_frame u_frame (
        .clk_100  (clk_100),
        .reset    (reset),
        .host_bus (host_bus),
        .frame    (frame)
    );

    ////////////////////
    // function blocks
    ////////////////////

    user_regs u_regs (
        .clk_100            (clk_100),
        .reset              (reset),
        .frame              (frame),
        .buttons            (buttons),
        .forced_scandoubler (forced_scandoubler),
        .joystick_0         (joystick_0),
        .joystick_1         (joystick_1),
        .status             (status)
    );

    file_loader u_loader (
        .clk_100        (clk_100),
        .reset          (reset),
        .frame          (frame),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_index    (ioctl_index),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout)
    );

    // only read path back to the host
    kbd_host u_kbd (
        .clk_100    (clk_100),
        .reset      (reset),
        .frame      (frame),
        .led_status (ps2_kbd_led_status),
        .led_use    (ps2_kbd_led_use),
        .io_dout    (io_dout),
        .ps2_key    (ps2_key),
        .kbd_byte   (kbd_byte),
        .kbd_push   (kbd_push)
    );

    ps2_kbd_tx u_ps2_tx (
        .clk_100      (clk_100),
        .reset        (reset),
        .kbd_byte     (kbd_byte),
        .kbd_push     (kbd_push),
        .ps2_clk_out  (ps2_kbd_clk_out),
        .ps2_data_out (ps2_kbd_data_out)
    );

endmodule

// File: tb_hps_io.sv
module tb_hps_io;
    import hps_io_pkg::*;

    ////////////////////
    // test table
    ////////////////////

    // frame kinds select their own checks
    localparam logic [3:0] k_cfg    = 4'd0;
    localparam logic [3:0] k_joy0   = 4'd1;
    localparam logic [3:0] k_joy1   = 4'd2;
    localparam logic [3:0] k_status = 4'd3;
    localparam logic [3:0] k_index  = 4'd4;
    localparam logic [3:0] k_addr   = 4'd5;
    localparam logic [3:0] k_tx_on  = 4'd6;
    localparam logic [3:0] k_dat    = 4'd7;
    localparam logic [3:0] k_tx_off = 4'd8;
    localparam logic [3:0] k_key    = 4'd9;
    localparam logic [3:0] k_led    = 4'd10;
    localparam int n_tests = 15;

    // one host frame plus the value it should leave behind
    typedef struct packed {
        logic [3:0]       kind;
        io_word_t         cmd;
        logic [3:0]       len;
        logic [7:0][15:0] words;
        logic [2:0]       led_status;
        logic [2:0]       led_use;
        logic [31:0]      exp;
    } frame_entry_t;

    // due marks when addr and data of a pending download write must show
    typedef struct packed {
        logic [63:0] due;
        ioctl_addr_t addr;
        io_byte_t    data;
    } write_exp_t;

    logic        clk_100;
    logic        reset;
    host_bus_t   host_bus;
    io_word_t    io_dout;
    logic [1:0]  buttons;
    logic        forced_scandoubler;
    io_word_t    joystick_0;
    io_word_t    joystick_1;
    logic [31:0] status;
    logic        ioctl_download;
    logic        ioctl_wr;
    io_byte_t    ioctl_index;
    ioctl_addr_t ioctl_addr;
    io_byte_t    ioctl_dout;
    logic [2:0]  ps2_kbd_led_status;
    logic [2:0]  ps2_kbd_led_use;
    ps2_key_t    ps2_key;
    logic        ps2_kbd_clk_out;
    logic        ps2_kbd_data_out;

    frame_entry_t tests [n_tests];
    write_exp_t   wr_exp_q [$];
    logic [63:0]  pulse_due_q [$];
    logic [10:0]  ps2_frames_q [$];
    io_byte_t     ps2_exp_q [$];
    write_exp_t   wr_now;
    logic [10:0]  cap_bits;
    int           cap_cnt;
    int           wr_pulses;
    int           errors;
    int           tests_run;
    logic [31:0]  rand_state;
    io_word_t     last_dout;
    logic         exp_toggle;

    hps_io DUT (.*);

    always #5 clk_100 = ~clk_100;

    ////////////////////
    // reference rules
    ////////////////////

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic carries_address(input io_word_t cmd, input int k);
        return (cmd == cmd_file_addr_tx) && (k <= 4);
    endfunction

    function automatic logic carries_data(input io_word_t cmd, input int k);
        return (cmd == cmd_file_dat) || ((cmd == cmd_file_addr_tx) && (k > 4));
    endfunction

    function automatic int count_data_words(input frame_entry_t e);
        int n;
        n = 0;
        for (int k = 1; k <= e.len; k++)
            if (carries_data(e.cmd, k))
                n++;
        return n;
    endfunction

    // {pressed, extended, code} of a scan byte sequence
    function automatic logic [9:0] key_rule(input logic [7:0][15:0] w, input int n);
        logic [7:0] last;
        logic       pressed;
        logic       extended;
        int         k;
        last = w[n-1][7:0];
        // print screen press is the extended 7C key
        if (n >= 4 && {w[n-4][7:0], w[n-3][7:0], w[n-2][7:0], last} == 32'hE012E07C)
            return {1'b1, 1'b1, 8'h7C};
        // step back over a break byte to reach a possible prefix
        k = n - 2;
        pressed = 1'b1;
        if (k >= 0 && w[k][7:0] == 8'hF0) begin
            pressed = 1'b0;
            k--;
        end
        extended = (k >= 0) && (w[k][7:0] == 8'hE0);
        return {pressed, extended, last};
    endfunction

    // one status and use pair per led above a 01 marker
    function automatic io_word_t led_rule(input logic [2:0] stat3, input logic [2:0] used3);
        io_word_t r;
        r = 16'h0040;
        for (int i = 0; i < 3; i++) begin
            r[2*i+1] = stat3[i];
            r[2*i]   = used3[i];
        end
        return r;
    endfunction

    function automatic frame_entry_t make_entry(input logic [3:0] kind, input io_word_t cmd,
            input logic [3:0] len, input logic [7:0][15:0] w,
            input logic [2:0] stat3, input logic [2:0] used3);
        frame_entry_t e;
        e.kind       = kind;
        e.cmd        = cmd;
        e.len        = len;
        e.words      = w;
        e.led_status = stat3;
        e.led_use    = used3;
        case (kind)
            k_cfg:            e.exp = {27'd0, w[0][4], 2'b00, w[0][1:0]};
            k_joy0, k_joy1:   e.exp = {16'd0, w[0]};
            k_status:         e.exp = {w[1], w[0]};
            k_index:          e.exp = {24'd0, w[0][7:0]};
            // only 25 bits of the start address survive the shift
            k_addr:           e.exp = {w[0][7:0], w[1][7:0], w[2][7:0], w[3][7:0]}
                                      & 32'h01FF_FFFF;
            k_tx_on, k_tx_off: e.exp = {31'd0, |w[0][7:0]};
            k_dat:            e.exp = 32'd0;
            k_key:            e.exp = {22'd0, key_rule(w, len)};
            default:          e.exp = {16'd0, led_rule(stat3, used3)};
        endcase
        return e;
    endfunction

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            k_cfg:    return "config";
            k_joy0:   return "joystick 0";
            k_joy1:   return "joystick 1";
            k_status: return "status";
            k_index:  return "file index";
            k_addr:   return "addressed download";
            k_tx_on:  return "download open";
            k_dat:    return "plain download data";
            k_tx_off: return "download close";
            k_key:    return "key event";
            default:  return "led readback";
        endcase
    endfunction

    task automatic build_table();
        logic [7:0][15:0] w;
        w = '0;
        w[0] = 16'h0032;
        tests[0] = make_entry(k_cfg, cmd_cfg, 1, w, 0, 0);
        rand_state = next_rand(rand_state);
        w[0] = rand_state[31:16];
        tests[1] = make_entry(k_joy0, cmd_joy0, 1, w, 0, 0);
        rand_state = next_rand(rand_state);
        w[0] = rand_state[31:16];
        tests[2] = make_entry(k_joy1, cmd_joy1, 1, w, 0, 0);
        rand_state = next_rand(rand_state);
        w[0] = rand_state[31:16];
        rand_state = next_rand(rand_state);
        w[1] = rand_state[31:16];
        tests[3] = make_entry(k_status, cmd_status, 2, w, 0, 0);
        // plain download opens while no download is running
        w = '0;
        w[0] = 16'h0001;
        tests[4] = make_entry(k_tx_on, cmd_file_tx, 1, w, 0, 0);
        w[0] = 16'h0011;
        w[1] = 16'h0022;
        w[2] = 16'h0033;
        w[3] = 16'h0044;
        tests[5] = make_entry(k_dat, cmd_file_dat, 4, w, 0, 0);
        w = '0;
        tests[6] = make_entry(k_tx_off, cmd_file_tx, 1, w, 0, 0);
        w[0] = 16'h0004;
        tests[7] = make_entry(k_index, cmd_file_index, 1, w, 0, 0);
        // four address bytes msb first and then three data bytes
        w[0] = 16'h0001;
        w[1] = 16'h0023;
        w[2] = 16'h0045;
        w[3] = 16'h0067;
        w[4] = 16'h00A5;
        w[5] = 16'h005A;
        w[6] = 16'h00C3;
        tests[8] = make_entry(k_addr, cmd_file_addr_tx, 7, w, 0, 0);
        w = '0;
        // make code
        w[0] = 16'h001C;
        tests[9] = make_entry(k_key, cmd_kbd, 1, w, 0, 0);
        // extended break
        w[0] = 16'h00E0;
        w[1] = 16'h00F0;
        w[2] = 16'h0075;
        tests[10] = make_entry(k_key, cmd_kbd, 3, w, 0, 0);
        // print screen press
        w[0] = 16'h00E0;
        w[1] = 16'h0012;
        w[2] = 16'h00E0;
        w[3] = 16'h007C;
        tests[11] = make_entry(k_key, cmd_kbd, 4, w, 0, 0);
        w = '0;
        tests[12] = make_entry(k_led, cmd_led, 1, w, 3'b101, 3'b011);
        tests[13] = make_entry(k_led, cmd_led, 1, w, 3'b111, 3'b000);
        tests[14] = make_entry(k_led, cmd_led, 1, w, 3'b010, 3'b110);
    endtask

    ////////////////////
    // checks
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_base);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_base) ? "ok" : "mismatch");
    endtask

    // addr and data show one cycle after the strobe and the pulse one cycle later
    always @(posedge clk_100) begin
        if (wr_exp_q.size() > 0 && wr_exp_q[0].due == $time) begin
            wr_now = wr_exp_q.pop_front();
            check_value("ioctl_addr", ioctl_addr, wr_now.addr);
            check_value("ioctl_dout", ioctl_dout, wr_now.data);
            pulse_due_q.push_back($time + 10);
        end
        if (ioctl_wr === 1'b1) begin
            wr_pulses++;
            assert (pulse_due_q.size() > 0 && pulse_due_q[0] == $time) else begin
                $display("ioctl_wr pulse at %0t is not two cycles after a data strobe", $time);
                errors++;
            end
            if (pulse_due_q.size() > 0)
                void'(pulse_due_q.pop_front());
        end else if (pulse_due_q.size() > 0) begin
            assert (pulse_due_q[0] > $time) else begin
                $display("ioctl_wr pulse missing at %0t", $time);
                errors++;
                void'(pulse_due_q.pop_front());
            end
        end
    end

    // one ps/2 frame bit per falling clock
    always @(negedge ps2_kbd_clk_out) begin
        if (!reset) begin
            cap_bits = {ps2_kbd_data_out, cap_bits[10:1]};
            cap_cnt++;
            if (cap_cnt == 11) begin
                ps2_frames_q.push_back(cap_bits);
                cap_cnt = 0;
            end
        end
    end

    ////////////////////
    // frame driver
    ////////////////////

    task automatic send_frame(input frame_entry_t e);
        ioctl_addr_t run_addr;
        // target address restarts with each frame
        run_addr = '0;
        @(posedge clk_100);
        host_bus <= '{enable: 1'b1, strobe: 1'b0, din: '0};
        @(posedge clk_100);
        host_bus <= '{enable: 1'b1, strobe: 1'b1, din: e.cmd};
        for (int k = 1; k <= e.len; k++) begin
            @(posedge clk_100);
            host_bus <= '{enable: 1'b1, strobe: 1'b1, din: e.words[k-1]};
            if (carries_address(e.cmd, k)) begin
                run_addr = {run_addr[16:0], e.words[k-1][7:0]};
            end else if (carries_data(e.cmd, k)) begin
                wr_exp_q.push_back('{due: $time + 20, addr: run_addr,
                                     data: e.words[k-1][7:0]});
                run_addr = run_addr + 1'b1;
            end
            if (e.cmd == cmd_kbd)
                ps2_exp_q.push_back(e.words[k-1][7:0]);
        end
        @(posedge clk_100);
        host_bus <= '0;
        // readback one cycle after the last payload strobe
        @(posedge clk_100);
        last_dout = io_dout;
        repeat (2) @(posedge clk_100);
    endtask

    task automatic wait_writes_drained();
        int n;
        n = 0;
        while ((wr_exp_q.size() > 0 || pulse_due_q.size() > 0) && n < 200) begin
            @(posedge clk_100);
            n++;
        end
        assert (wr_exp_q.size() == 0 && pulse_due_q.size() == 0) else begin
            $display("download writes still pending after 200 cycles");
            errors++;
        end
    endtask

    task automatic wait_key_toggle(input logic want);
        int n;
        n = 0;
        while (ps2_key.toggle !== want && n < 200) begin
            @(posedge clk_100);
            n++;
        end
        assert (ps2_key.toggle === want) else begin
            $display("no key event after 200 cycles");
            errors++;
        end
    endtask

    task automatic check_entry(input frame_entry_t e, input int pulse_base);
        int n_data;
        n_data = count_data_words(e);
        case (e.kind)
            k_cfg: begin
                check_value("buttons", buttons, e.exp[1:0]);
                check_value("forced_scandoubler", forced_scandoubler, e.exp[4]);
            end
            k_joy0:   check_value("joystick_0", joystick_0, e.exp[15:0]);
            k_joy1:   check_value("joystick_1", joystick_1, e.exp[15:0]);
            k_status: check_value("status", status, e.exp);
            k_index:  check_value("ioctl_index", ioctl_index, e.exp[7:0]);
            k_addr, k_dat: begin
                check_value("ioctl_download", ioctl_download, 1);
                // last write sits at start plus count minus one
                check_value("ioctl_addr", ioctl_addr, (e.exp + n_data - 1) & 32'h01FF_FFFF);
            end
            k_tx_on, k_tx_off: check_value("ioctl_download", ioctl_download, e.exp[0]);
            k_key: begin
                exp_toggle = ~exp_toggle;
                wait_key_toggle(exp_toggle);
                check_value("ps2_key.pressed", ps2_key.pressed, e.exp[9]);
                check_value("ps2_key.extended", ps2_key.extended, e.exp[8]);
                check_value("ps2_key.code", ps2_key.code, e.exp[7:0]);
            end
            default: check_value("io_dout", last_dout, e.exp[15:0]);
        endcase
        check_value("ioctl_wr pulse count", wr_pulses - pulse_base, n_data);
        // nothing on the read path outside a frame
        check_value("io_dout", io_dout, 0);
    endtask

    task automatic check_ps2_stream();
        int n;
        logic [10:0] f;
        io_byte_t b;
        for (int i = 0; i < ps2_exp_q.size(); i++) begin
            n = 0;
            while (ps2_frames_q.size() <= i && n < 60000) begin
                @(posedge clk_100);
                n++;
            end
            assert (ps2_frames_q.size() > i) else begin
                $display("PS/2 byte %0d never appeared on the wire", i + 1);
                errors++;
                break;
            end
            f = ps2_frames_q[i];
            b = ps2_exp_q[i];
            check_value("ps2 start bit", f[0], 0);
            check_value("ps2 data byte", f[8:1], b);
            // odd parity over data plus parity bit
            check_value("ps2 parity bit", f[9], ~^b);
            check_value("ps2 stop bit", f[10], 1);
        end
        check_value("ps2 frame count", ps2_frames_q.size(), ps2_exp_q.size());
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int err_base;
        int pulse_base;
        clk_100            = 1'b0;
        reset              = 1'b1;
        host_bus           = '0;
        ps2_kbd_led_status = '0;
        ps2_kbd_led_use    = '0;
        errors             = 0;
        wr_pulses          = 0;
        tests_run          = 0;
        cap_cnt            = 0;
        cap_bits           = '0;
        last_dout          = '0;
        exp_toggle         = 1'b0;
        rand_state         = 32'd44880;
        build_table();

        repeat (5) @(posedge clk_100);
        reset <= 1'b0;
        @(posedge clk_100);

        // idle state straight out of reset
        err_base = errors;
        check_value("ps2_kbd_clk_out", ps2_kbd_clk_out, 1);
        check_value("ps2_kbd_data_out", ps2_kbd_data_out, 1);
        check_value("ioctl_wr", ioctl_wr, 0);
        check_value("ioctl_download", ioctl_download, 0);
        check_value("io_dout", io_dout, 0);
        check_value("ps2_key", ps2_key, 0);
        report_test("reset", err_base);

        for (int i = 0; i < n_tests; i++) begin
            err_base   = errors;
            pulse_base = wr_pulses;
            @(posedge clk_100);
            ps2_kbd_led_status <= tests[i].led_status;
            ps2_kbd_led_use    <= tests[i].led_use;
            send_frame(tests[i]);
            wait_writes_drained();
            check_entry(tests[i], pulse_base);
            report_test(kind_name(tests[i].kind), err_base);
        end

        // serial bytes of all key frames in push order
        err_base = errors;
        check_ps2_stream();
        report_test("ps2 serial output", err_base);

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: verilog.f
hps_io_pkg.sv
host_cmd_frame.sv
user_regs.sv
file_loader.sv
kbd_host.sv
ps2_kbd_tx.sv
hps_io.sv
tb_hps_io.sv
